// File: source/saturn_dbg_pkg.sv
// Shared constants for the register-dump debugger
// Register codes, dump layout states, field label text and hex conversion
package saturn_dbg_pkg;

    localparam int CHAR_W      = 8;             // One ASCII character
    localparam int PC_W        = 20;            // PC and return-stack values
    localparam int PC_NIBBLES  = 5;
    localparam int ST_W        = 16;
    localparam int HST_W       = 4;
    localparam int REG_NIBBLES = 16;            // 64-bit working registers
    localparam int RSTK_DEPTH  = 8;
    localparam int RSTK_PTR_W  = 3;
    localparam int ALU_REG_W   = 5;
    localparam int DUMP_LEN    = 183;           // Characters in one snapshot

    // Label text is right aligned in an eight character field
    localparam int LBL_W = 8 * CHAR_W;

    localparam logic [LBL_W-1:0] LBL_PC   = "PC: ";
    localparam logic [LBL_W-1:0] LBL_MODE = " h: ";
    localparam logic [LBL_W-1:0] LBL_RP   = " rp: ";
    localparam logic [LBL_W-1:0] LBL_P    = "P: ";
    localparam logic [LBL_W-1:0] LBL_HST  = " HST: ";
    localparam logic [LBL_W-1:0] LBL_ST   = " ST: ";
    localparam logic [LBL_W-1:0] LBL_C    = "C: ";
    localparam logic [LBL_W-1:0] LBL_DEC  = "DEC";
    localparam logic [LBL_W-1:0] LBL_HEX  = "HEX";

    localparam int LBL_PC_LEN   = 4;
    localparam int LBL_MODE_LEN = 4;
    localparam int LBL_RP_LEN   = 5;
    localparam int LBL_P_LEN    = 3;
    localparam int LBL_HST_LEN  = 6;
    localparam int LBL_ST_LEN   = 5;
    localparam int LBL_C_LEN    = 3;
    localparam int LBL_RSTK_LEN = 7;            // "RSTKn: "
    localparam int MODE_TXT_LEN = 3;            // DEC or HEX

    typedef enum logic [ALU_REG_W-1:0] {
        ALU_REG_C    = 5'd2,
        ALU_REG_NONE = 5'd31
    } alu_reg_t;

    // One state per field of the snapshot, in output order
    typedef enum logic [3:0] {
        DUMP_PC, DUMP_MODE, DUMP_RP, DUMP_NL0,
        DUMP_P, DUMP_HST, DUMP_ST, DUMP_NL1,
        DUMP_CREG, DUMP_NL2, DUMP_RSTK, DUMP_DONE
    } dump_state_t;

    function automatic logic [CHAR_W-1:0] hex_char(input logic [3:0] nibble);
        if (nibble < 4'd10) begin
            return CHAR_W'("0") + CHAR_W'(nibble);
        end
        return CHAR_W'("A") + CHAR_W'(nibble) - CHAR_W'(10);
    endfunction

endpackage

// File: source/dump_sequencer.sv
// Snapshot layout FSM for the debugger
// Walks the dump fields, reads CPU state and offers one character per cycle
`timescale 1ns/100ps

module dump_sequencer import saturn_dbg_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_instr_decoded,
    input  logic [PC_W-1:0]       i_current_pc,
    input  logic                  i_reg_alu_mode,
    input  logic [RSTK_PTR_W-1:0] i_reg_rstk_ptr,
    input  logic [3:0]            i_reg_p,
    input  logic [HST_W-1:0]      i_reg_hst,
    input  logic [ST_W-1:0]       i_reg_st,
    input  logic [3:0]            i_dbg_reg_nibble,
    input  logic [PC_W-1:0]       i_dbg_rstk_val,
    input  logic                  i_char_ready,
    input  logic                  i_last_sent,     // Final character left the output
    output logic                  o_debug_cycle,
    output alu_reg_t              o_dbg_register,
    output logic [3:0]            o_dbg_reg_ptr,
    output logic [RSTK_PTR_W-1:0] o_dbg_rstk_ptr,
    output logic [CHAR_W-1:0]     o_char,
    output logic                  o_char_valid,
    output logic                  o_char_last
);

    dump_state_t           state;
    dump_state_t           next_state;
    logic [4:0]            pos;                  // Character index inside the field
    logic [RSTK_PTR_W-1:0] rstk_idx;

    logic [LBL_W-1:0]      lbl;
    logic [LBL_W-1:0]      txt;
    logic [PC_W-1:0]       dig_val;
    logic                  dig_bin;              // Digits are single bits
    logic                  dig_txt;              // Digits are fixed text
    logic                  dig_fixed;            // Nibble comes straight from the read port
    logic                  nl_end;
    int                    lbl_len;
    int                    dig_cnt;
    int                    pos_int;
    int                    dig_int;
    int                    dsel;
    int                    fld_len;
    logic                  fld_last;
    logic [CHAR_W-1:0]     char_now;
    logic                  fire;

    function automatic logic [CHAR_W-1:0] label_char(input logic [LBL_W-1:0] text,
                                                      input int len, input int idx);
        return text[CHAR_W*(len-1-idx) +: CHAR_W];
    endfunction

    // Field description: label, digit source and digit count
    always_comb begin
        lbl        = '0;
        txt        = '0;
        lbl_len    = 0;
        dig_cnt    = 0;
        dig_val    = '0;
        dig_bin    = 1'b0;
        dig_txt    = 1'b0;
        dig_fixed  = 1'b0;
        nl_end     = 1'b0;
        next_state = dump_state_t'(state + 4'd1);
        case (state)
            DUMP_PC: begin
                lbl     = LBL_PC;
                lbl_len = LBL_PC_LEN;
                dig_cnt = PC_NIBBLES;
                dig_val = i_current_pc;
            end
            DUMP_MODE: begin
                lbl     = LBL_MODE;
                lbl_len = LBL_MODE_LEN;
                dig_cnt = MODE_TXT_LEN;
                dig_txt = 1'b1;
                txt     = i_reg_alu_mode ? LBL_DEC : LBL_HEX;
            end
            DUMP_RP: begin
                lbl     = LBL_RP;
                lbl_len = LBL_RP_LEN;
                dig_cnt = 1;
                dig_val = PC_W'(i_reg_rstk_ptr);
            end
            DUMP_P: begin
                lbl     = LBL_P;
                lbl_len = LBL_P_LEN;
                dig_cnt = 1;
                dig_val = PC_W'(i_reg_p);
            end
            DUMP_HST: begin
                lbl     = LBL_HST;
                lbl_len = LBL_HST_LEN;
                dig_cnt = HST_W;
                dig_bin = 1'b1;
                dig_val = PC_W'(i_reg_hst);
            end
            DUMP_ST: begin
                lbl     = LBL_ST;
                lbl_len = LBL_ST_LEN;
                dig_cnt = ST_W;
                dig_bin = 1'b1;
                dig_val = PC_W'(i_reg_st);
            end
            DUMP_CREG: begin
                lbl       = LBL_C;
                lbl_len   = LBL_C_LEN;
                dig_cnt   = REG_NIBBLES;
                dig_fixed = 1'b1;
                dig_val   = PC_W'(i_dbg_reg_nibble);
            end
            DUMP_RSTK: begin
                lbl     = {CHAR_W'(0), "RSTK", hex_char(4'(rstk_idx)), ": "};
                lbl_len = LBL_RSTK_LEN;
                dig_cnt = PC_NIBBLES;
                dig_val = i_dbg_rstk_val;
                nl_end  = 1'b1;
                if (rstk_idx != '0) begin
                    next_state = DUMP_RSTK;              // Next entry down
                end
            end
            DUMP_NL0, DUMP_NL1, DUMP_NL2: begin
                nl_end = 1'b1;
            end
            default: begin
                next_state = DUMP_DONE;
            end
        endcase
    end

    // Character at the current position
    always_comb begin
        pos_int  = int'(pos);
        dig_int  = pos_int - lbl_len;
        dsel     = dig_cnt - 1 - dig_int;            // Digit weight, MSB first
        fld_len  = lbl_len + dig_cnt + int'(nl_end);
        fld_last = (pos_int == fld_len - 1);
        if (pos_int < lbl_len) begin
            char_now = label_char(lbl, lbl_len, pos_int);
        end else if (dig_int >= dig_cnt) begin
            char_now = "\n";
        end else if (dig_txt) begin
            char_now = label_char(txt, dig_cnt, dig_int);
        end else if (dig_bin) begin
            char_now = dig_val[dsel] ? "1" : "0";
        end else if (dig_fixed) begin
            char_now = hex_char(dig_val[3:0]);
        end else begin
            char_now = hex_char(4'(dig_val >> (4 * dsel)));
        end
    end

    assign o_char       = char_now;
    assign o_char_valid = o_debug_cycle && (state != DUMP_DONE);
    assign o_char_last  = (state == DUMP_RSTK) && (rstk_idx == '0) && fld_last;
    assign fire         = o_char_valid && i_char_ready;

    // Read ports follow the digit being produced
    assign o_dbg_register = (state == DUMP_CREG && pos_int >= LBL_C_LEN) ?
                            ALU_REG_C : ALU_REG_NONE;
    assign o_dbg_reg_ptr  = 4'(REG_NIBBLES - 1 - dig_int);
    assign o_dbg_rstk_ptr = rstk_idx;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_debug_cycle <= 1'b0;
            state         <= DUMP_DONE;
            pos           <= '0;
            rstk_idx      <= '0;
        end else if (!o_debug_cycle) begin
            if (i_instr_decoded) begin
                o_debug_cycle <= 1'b1;
                state         <= DUMP_PC;
                pos           <= '0;
                rstk_idx      <= RSTK_PTR_W'(RSTK_DEPTH - 1);
            end
        end else begin
            if (i_last_sent) begin
                o_debug_cycle <= 1'b0;
            end
            if (fire) begin
                if (fld_last) begin
                    pos   <= '0;
                    state <= next_state;
                    if (state == DUMP_RSTK) begin
                        rstk_idx <= rstk_idx - 1'b1;
                    end
                end else begin
                    pos <= pos + 5'd1;
                end
            end
        end
    end

endmodule

// File: source/char_fifo.sv
// Small valid/ready FIFO for dump characters
// Each entry holds one character and its last-character flag
`timescale 1ns/100ps

module char_fifo import saturn_dbg_pkg::*; #(
    parameter int DEPTH = 4                      // Power of two
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic [CHAR_W-1:0] i_char,
    input  logic              i_last,
    input  logic              i_valid,
    input  logic              i_ready,
    output logic              o_ready,
    output logic [CHAR_W-1:0] o_char,
    output logic              o_last,
    output logic              o_valid
);

    logic [CHAR_W:0]            mem [DEPTH];     // {last, char}
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH):0]     count;
    logic                       push;
    logic                       pop;

    assign o_ready = !count[$clog2(DEPTH)];      // Top bit only set when full
    assign o_valid = (count != '0);
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;

    assign {o_last, o_char} = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= {i_last, i_char};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: source/saturn_debugger.sv
// Register-dump debugger top level
// Layout sequencer feeding a character FIFO toward the serial port
`timescale 1ns/100ps

module saturn_debugger import saturn_dbg_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    output logic                  o_debug_cycle,
    // CPU state, held stable during a dump
    input  logic                  i_instr_decoded,
    input  logic [PC_W-1:0]       i_current_pc,
    input  logic                  i_reg_alu_mode,
    input  logic [RSTK_PTR_W-1:0] i_reg_rstk_ptr,
    input  logic [3:0]            i_reg_p,
    input  logic [HST_W-1:0]      i_reg_hst,
    input  logic [ST_W-1:0]       i_reg_st,
    // Read ports into the core
    output alu_reg_t              o_dbg_register,
    output logic [3:0]            o_dbg_reg_ptr,
    input  logic [3:0]            i_dbg_reg_nibble,
    output logic [RSTK_PTR_W-1:0] o_dbg_rstk_ptr,
    input  logic [PC_W-1:0]       i_dbg_rstk_val,
    // Serial output
    output logic [CHAR_W-1:0]     o_char,
    output logic                  o_char_valid,
    input  logic                  i_char_ready
);

    logic [CHAR_W-1:0] seq_char;
    logic              seq_valid;
    logic              seq_last;
    logic              fifo_ready;
    logic              fifo_last;
    logic              last_sent;

    // Dump ends once the flagged character is taken by the serial side
    assign last_sent = o_char_valid && i_char_ready && fifo_last;

    dump_sequencer dump_sequencer_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_instr_decoded  (i_instr_decoded),
        .i_current_pc     (i_current_pc),
        .i_reg_alu_mode   (i_reg_alu_mode),
        .i_reg_rstk_ptr   (i_reg_rstk_ptr),
        .i_reg_p          (i_reg_p),
        .i_reg_hst        (i_reg_hst),
        .i_reg_st         (i_reg_st),
        .i_dbg_reg_nibble (i_dbg_reg_nibble),
        .i_dbg_rstk_val   (i_dbg_rstk_val),
        .i_char_ready     (fifo_ready),
        .i_last_sent      (last_sent),
        .o_debug_cycle    (o_debug_cycle),
        .o_dbg_register   (o_dbg_register),
        .o_dbg_reg_ptr    (o_dbg_reg_ptr),
        .o_dbg_rstk_ptr   (o_dbg_rstk_ptr),
        .o_char           (seq_char),
        .o_char_valid     (seq_valid),
        .o_char_last      (seq_last)
    );

    char_fifo #(
        .DEPTH (4)
    ) char_fifo_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_char  (seq_char),
        .i_last  (seq_last),
        .i_valid (seq_valid),
        .i_ready (i_char_ready),
        .o_ready (fifo_ready),
        .o_char  (o_char),
        .o_last  (fifo_last),
        .o_valid (o_char_valid)
    );

endmodule

// File: test/saturn_debugger_asserts.sv
// Concurrent checks on the debugger output handshake and register port
`timescale 1ns/100ps

module saturn_debugger_asserts import saturn_dbg_pkg::*; (
    input logic              i_clk,
    input logic              i_reset,
    input logic              i_debug_cycle,
    input alu_reg_t          i_dbg_register,
    input logic [CHAR_W-1:0] i_char,
    input logic              i_char_valid,
    input logic              i_char_ready
);

    int fail_count = 0;                          // Assertion failures so far

    // A stalled character stays offered and unchanged
    stall_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        i_char_valid && !i_char_ready |=> i_char_valid && $stable(i_char))
        else begin
            $error("character changed during a stall");
            fail_count++;
        end

    valid_in_dump: assert property (@(posedge i_clk) disable iff (i_reset)
        i_char_valid |-> i_debug_cycle)
        else begin
            $error("character offered outside a dump");
            fail_count++;
        end

    // Core register file is left alone between dumps
    reg_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_debug_cycle |-> i_dbg_register == ALU_REG_NONE)
        else begin
            $error("register port active while idle");
            fail_count++;
        end

endmodule

bind saturn_debugger saturn_debugger_asserts saturn_debugger_asserts_i (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_debug_cycle  (o_debug_cycle),
    .i_dbg_register (o_dbg_register),
    .i_char         (o_char),
    .i_char_valid   (o_char_valid),
    .i_char_ready   (i_char_ready)
);

// File: test/tb_saturn_debugger.sv
// Testbench for the register-dump debugger
// Random CPU state model, expected-text builder and per-character checks
`timescale 1ns/100ps

module tb_saturn_debugger import saturn_dbg_pkg::*; ();

    logic                  i_clk;
    logic                  i_reset;
    logic                  i_instr_decoded;
    logic [PC_W-1:0]       i_current_pc;
    logic                  i_reg_alu_mode;
    logic [RSTK_PTR_W-1:0] i_reg_rstk_ptr;
    logic [3:0]            i_reg_p;
    logic [HST_W-1:0]      i_reg_hst;
    logic [ST_W-1:0]       i_reg_st;
    logic [3:0]            i_dbg_reg_nibble;
    logic [PC_W-1:0]       i_dbg_rstk_val;
    logic                  i_char_ready;
    logic                  o_debug_cycle;
    alu_reg_t              o_dbg_register;
    logic [3:0]            o_dbg_reg_ptr;
    logic [RSTK_PTR_W-1:0] o_dbg_rstk_ptr;
    logic [CHAR_W-1:0]     o_char;
    logic                  o_char_valid;

    logic [4*REG_NIBBLES-1:0] c_reg;            // Core C register
    logic [PC_W-1:0]          rstk [RSTK_DEPTH];
    logic [31:0]              rng_state;
    byte unsigned             exp_text [$];
    int                       total_errors = 0;
    int                       char_checks = 0;
    int                       test_num = 0;
    int                       errors_at_start;
    string                    test_name;
    int                       max_stall = 3;    // Longest run of ready low
    int                       dump_total = 11;  // Dumps started over the whole run

    saturn_debugger saturn_debugger_i (.*);

    // Core read ports answer in the same cycle
    always_comb begin
        i_dbg_reg_nibble = 4'h0;
        if (o_dbg_register == ALU_REG_C) begin
            i_dbg_reg_nibble = c_reg[4*o_dbg_reg_ptr +: 4];
        end
        i_dbg_rstk_val = rstk[o_dbg_rstk_ptr];
    end

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    initial begin
        int limit_ns;
        limit_ns = dump_total * DUMP_LEN * (max_stall + 1) * 10 + 5000;
        #(limit_ns);
        $display("Timeout: run still busy after %0d ns", limit_ns);
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic void put_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            exp_text.push_back(s[i]);
        end
    endfunction

    function automatic void put_hex(input logic [3:0] n);
        string digits = "0123456789ABCDEF";
        exp_text.push_back(digits[n]);
    endfunction

    function automatic void put_bit(input logic b);
        if (b) begin
            put_text("1");
        end else begin
            put_text("0");
        end
    endfunction

    // Snapshot text as the serial side should see it
    function automatic void build_expected();
        exp_text.delete();
        put_text("PC: ");
        for (int i = PC_NIBBLES - 1; i >= 0; i--) begin
            put_hex(i_current_pc[4*i +: 4]);
        end
        put_text(" h: ");
        if (i_reg_alu_mode) begin
            put_text("DEC");
        end else begin
            put_text("HEX");
        end
        put_text(" rp: ");
        put_hex(4'(i_reg_rstk_ptr));
        put_text("\nP: ");
        put_hex(i_reg_p);
        put_text(" HST: ");
        for (int i = HST_W - 1; i >= 0; i--) begin
            put_bit(i_reg_hst[i]);
        end
        put_text(" ST: ");
        for (int i = ST_W - 1; i >= 0; i--) begin
            put_bit(i_reg_st[i]);
        end
        put_text("\nC: ");
        for (int i = REG_NIBBLES - 1; i >= 0; i--) begin
            put_hex(c_reg[4*i +: 4]);
        end
        put_text("\n");
        for (int n = RSTK_DEPTH - 1; n >= 0; n--) begin
            put_text("RSTK");
            put_hex(4'(n));
            put_text(": ");
            for (int i = PC_NIBBLES - 1; i >= 0; i--) begin
                put_hex(rstk[n][4*i +: 4]);
            end
            put_text("\n");
        end
    endfunction

    task automatic report_error(input string msg);
        total_errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic randomize_state();
        logic [31:0] r;
        r = next_random();
        i_current_pc   = PC_W'(next_random());
        i_reg_alu_mode = r[0];
        i_reg_rstk_ptr = r[3:1];
        i_reg_p        = r[7:4];
        i_reg_hst      = r[11:8];
        i_reg_st       = r[27:12];
        c_reg          = {next_random(), next_random()};
        for (int i = 0; i < RSTK_DEPTH; i++) begin
            rstk[i] = PC_W'(next_random());
        end
    endtask

    // Triggers a dump and checks each character as the serial side takes it
    task automatic run_dump(input bit stalls, input bit pulses, input int stop_at);
        int          idx;
        int          stall_run;
        logic [31:0] r;
        idx       = 0;
        stall_run = 0;
        build_expected();
        @(negedge i_clk);
        i_instr_decoded = 1'b1;
        @(negedge i_clk);
        i_instr_decoded = 1'b0;
        while (idx < stop_at) begin
            if (o_debug_cycle !== 1'b1) begin
                report_error($sformatf("dump stopped after %0d characters", idx));
                break;
            end
            r = next_random();
            if (stalls && r[0] && stall_run < max_stall) begin
                i_char_ready = 1'b0;
                stall_run++;
            end else begin
                i_char_ready = 1'b1;
                stall_run = 0;
            end
            if (pulses) begin
                i_instr_decoded = r[8];         // Must be ignored mid-dump
            end
            if (o_char_valid === 1'b1 && i_char_ready) begin
                char_checks++;
                if (o_char !== exp_text[idx]) begin
                    total_errors++;
                    $display("Mismatch at %0d ns: character %0d expected 8'h%02h got 8'h%02h",
                             $time, idx, exp_text[idx], o_char);
                end
                idx++;
            end
            @(negedge i_clk);
        end
        i_instr_decoded = 1'b0;
        if (stop_at == DUMP_LEN) begin
            i_char_ready = 1'b1;
            if (o_debug_cycle !== 1'b0) begin
                report_error("o_debug_cycle still high after the last character");
            end
            repeat (4) begin
                if (o_char_valid !== 1'b0) begin
                    report_error("extra character offered after the dump");
                end
                @(negedge i_clk);
            end
        end
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name       = name;
        errors_at_start = total_errors;
    endtask

    task automatic finish_test();
        $display("Test %0d (%s): %0d errors", test_num, test_name,
                 total_errors - errors_at_start);
    endtask

    initial begin
        rng_state       = 32'h1f9d_bacc;
        i_reset         = 1'b1;
        i_instr_decoded = 1'b0;
        i_current_pc    = '0;
        i_reg_alu_mode  = 1'b0;
        i_reg_rstk_ptr  = '0;
        i_reg_p         = '0;
        i_reg_hst       = '0;
        i_reg_st        = '0;
        i_char_ready    = 1'b1;
        c_reg           = '0;
        for (int i = 0; i < RSTK_DEPTH; i++) begin
            rstk[i] = '0;
        end
        repeat (5) @(negedge i_clk);

        start_test("ready always high");
        if (o_debug_cycle !== 1'b0 || o_char_valid !== 1'b0) begin
            report_error("outputs active after reset");
        end
        if (o_dbg_register !== ALU_REG_NONE) begin
            report_error("register port selects a register after reset");
        end
        i_reset = 1'b0;
        randomize_state();
        run_dump(1'b0, 1'b0, DUMP_LEN);
        finish_test();

        start_test("random ready stalls");
        repeat (4) begin
            randomize_state();
            run_dump(1'b1, 1'b0, DUMP_LEN);
        end
        finish_test();

        start_test("DEC and HEX mode");
        randomize_state();
        i_reg_alu_mode = 1'b1;
        run_dump(1'b1, 1'b0, DUMP_LEN);
        i_reg_alu_mode = 1'b0;                  // Same state otherwise
        run_dump(1'b1, 1'b0, DUMP_LEN);
        finish_test();

        start_test("trigger pulses during a dump");
        repeat (2) begin
            randomize_state();
            run_dump(1'b1, 1'b1, DUMP_LEN);
        end
        finish_test();

        start_test("reset in the middle of a dump");
        randomize_state();
        run_dump(1'b1, 1'b0, 60);
        i_reset      = 1'b1;
        i_char_ready = 1'b1;
        @(negedge i_clk);
        if (o_debug_cycle !== 1'b0 || o_char_valid !== 1'b0) begin
            report_error("dump still active after reset");
        end
        @(negedge i_clk);
        i_reset = 1'b0;
        randomize_state();
        run_dump(1'b1, 1'b0, DUMP_LEN);
        finish_test();

        total_errors += saturn_debugger_i.saturn_debugger_asserts_i.fail_count;
        $display("Tests: %0d, characters checked: %0d, errors: %0d",
                 test_num, char_checks, total_errors);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/saturn_dbg_pkg.sv
source/dump_sequencer.sv
source/char_fifo.sv
source/saturn_debugger.sv
test/saturn_debugger_asserts.sv
test/tb_saturn_debugger.sv

// File: Makefile
# Verilator build and run for the register-dump debugger

VERILATOR ?= verilator
TOP       ?= tb_saturn_debugger
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
